// ==== verilog/riscv_pkg.sv ====
package riscv_pkg;

    // register width of rv64
    localparam int xlen = 64;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [4:0]      reg_idx_t;

    // major opcodes
    localparam logic [6:0] opcode_load  = 7'b0000011;
    localparam logic [6:0] opcode_store = 7'b0100011;

    // load funct3 codes
    localparam logic [2:0] funct3_lb  = 3'b000;
    localparam logic [2:0] funct3_lh  = 3'b001;
    localparam logic [2:0] funct3_lw  = 3'b010;
    localparam logic [2:0] funct3_ld  = 3'b011;
    localparam logic [2:0] funct3_lbu = 3'b100;
    localparam logic [2:0] funct3_lhu = 3'b101;
    localparam logic [2:0] funct3_lwu = 3'b110;

    // store funct3 codes
    localparam logic [2:0] funct3_sb = 3'b000;
    localparam logic [2:0] funct3_sh = 3'b001;
    localparam logic [2:0] funct3_sw = 3'b010;
    localparam logic [2:0] funct3_sd = 3'b011;

    // i-type layout, loads and register writes
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    // s-type layout, stores
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fields_t;

    // funct3 and opcode share their bits in both views
    typedef union packed {
        i_fields_t i_fields;
        s_fields_t s_fields;
    } inst_word_t;

endpackage

// ==== verilog/lsu_pkg.sv ====
package lsu_pkg;

    // data memory bus widths
    localparam int addr_w = 64;
    localparam int strb_w = 8;

    // full byte address
    typedef logic [addr_w-1:0] addr_t;

    // byte offset inside a doubleword
    typedef logic [2:0] lane_idx_t;

    // one bit per byte lane
    typedef logic [strb_w-1:0] strb_t;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word,
        size_double
    } access_size_t;

    // memory trace event kind, same codes as the old trace callout
    typedef enum logic [1:0] {
        trace_none  = 2'd0,
        trace_load  = 2'd1,
        trace_store = 2'd2
    } trace_kind_t;

endpackage

// ==== verilog/store_align.sv ====
module store_align (
    input  lsu_pkg::lane_idx_t    lane,
    input  lsu_pkg::access_size_t size,
    input  riscv_pkg::xlen_t      store_data,
    output riscv_pkg::xlen_t      lane_data,
    output lsu_pkg::strb_t        lane_strb
);
    import riscv_pkg::*;
    import lsu_pkg::*;

    // low bytes of the store data, not yet shifted
    xlen_t base_data;
    strb_t base_strb;

    always_comb begin
        case (size)
            size_byte: begin
                base_data = {56'b0, store_data[7:0]};
                base_strb = 8'h01;
            end
            size_half: begin
                base_data = {48'b0, store_data[15:0]};
                base_strb = 8'h03;
            end
            size_word: begin
                base_data = {32'b0, store_data[31:0]};
                base_strb = 8'h0f;
            end
            default: begin
                base_data = store_data;
                base_strb = 8'hff;
            end
        endcase
    end

    // aligned accesses only, so nothing spills past lane 7
    assign lane_data = base_data << {lane, 3'b000};
    assign lane_strb = base_strb << lane;

endmodule

// ==== verilog/load_extract.sv ====
module load_extract (
    input  riscv_pkg::xlen_t      rdata,
    input  lsu_pkg::lane_idx_t    lane,
    input  lsu_pkg::access_size_t size,
    input  logic                  signed_load,
    output riscv_pkg::xlen_t      value
);
    import riscv_pkg::*;
    import lsu_pkg::*;

    // addressed byte moved down to lane 0
    xlen_t shifted;
    // top bit of the selected item
    logic  sign_bit;

    assign shifted = rdata >> {lane, 3'b000};

    always_comb begin
        case (size)
            size_byte: begin
                sign_bit = signed_load & shifted[7];
                value    = {{56{sign_bit}}, shifted[7:0]};
            end
            size_half: begin
                sign_bit = signed_load & shifted[15];
                value    = {{48{sign_bit}}, shifted[15:0]};
            end
            size_word: begin
                sign_bit = signed_load & shifted[31];
                value    = {{32{sign_bit}}, shifted[31:0]};
            end
            default: begin
                // ld fills the whole register, no extension
                sign_bit = 1'b0;
                value    = shifted;
            end
        endcase
    end

endmodule

// ==== verilog/lsu_ctrl.sv ====
module lsu_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  riscv_pkg::xlen_t      in_pc,
    input  riscv_pkg::inst_word_t in_inst,
    input  riscv_pkg::xlen_t      in_alu_result,
    input  riscv_pkg::xlen_t      in_store_data,
    input  logic                  in_wen,
    output logic                  mem_req,
    output logic                  mem_we,
    output lsu_pkg::addr_t        mem_addr,
    output riscv_pkg::xlen_t      mem_wdata,
    output lsu_pkg::strb_t        mem_wstrb,
    input  logic                  mem_ack,
    input  riscv_pkg::xlen_t      mem_rdata,
    output logic                  done,
    output riscv_pkg::xlen_t      done_pc,
    output riscv_pkg::inst_word_t done_inst,
    output riscv_pkg::xlen_t      done_result,
    output logic                  done_wen,
    output lsu_pkg::trace_kind_t  done_kind,
    output lsu_pkg::addr_t        done_addr
);
    import riscv_pkg::*;
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait_release,
        st_finish
    } state_t;

    state_t       state;
    logic         accept;
    logic         dec_load;
    logic         dec_store;
    logic         dec_mem;
    access_size_t dec_size;
    logic         dec_signed;

    // accepted instruction, held until it leaves through done
    xlen_t        cap_pc;
    inst_word_t   cap_inst;
    addr_t        cap_addr;
    xlen_t        cap_data;
    logic         cap_wen;
    logic         cap_store;
    access_size_t cap_size;
    logic         cap_signed;
    xlen_t        cap_rdata;

    // non-memory item waiting one cycle on done
    logic         pass_valid;
    strb_t        lane_strb;
    xlen_t        load_value;

    // only one access in flight
    assign in_ready = (state == st_idle);
    assign accept   = in_valid && in_ready;
    assign dec_mem  = dec_load || dec_store;

    // unknown funct3 under a load or store opcode counts as non-memory
    always_comb begin
        dec_load   = 1'b0;
        dec_store  = 1'b0;
        dec_size   = size_double;
        dec_signed = 1'b0;
        if (in_inst.i_fields.opcode == opcode_load) begin
            dec_load = 1'b1;
            case (in_inst.i_fields.funct3)
                funct3_lb: begin
                    dec_size   = size_byte;
                    dec_signed = 1'b1;
                end
                funct3_lh: begin
                    dec_size   = size_half;
                    dec_signed = 1'b1;
                end
                funct3_lw: begin
                    dec_size   = size_word;
                    dec_signed = 1'b1;
                end
                funct3_ld:  dec_size = size_double;
                funct3_lbu: dec_size = size_byte;
                funct3_lhu: dec_size = size_half;
                funct3_lwu: dec_size = size_word;
                default:    dec_load = 1'b0;
            endcase
        end else if (in_inst.s_fields.opcode == opcode_store) begin
            dec_store = 1'b1;
            case (in_inst.s_fields.funct3)
                funct3_sb: dec_size = size_byte;
                funct3_sh: dec_size = size_half;
                funct3_sw: dec_size = size_word;
                funct3_sd: dec_size = size_double;
                default:   dec_store = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            mem_req    <= 1'b0;
            pass_valid <= 1'b0;
        end else begin
            pass_valid <= accept && !dec_mem;
            case (state)
                st_idle: begin
                    if (accept && dec_mem) begin
                        state <= st_req;
                    end
                end
                st_req: begin
                    // raise req only once the previous ack is gone
                    if (!mem_req && !mem_ack) begin
                        mem_req <= 1'b1;
                    end else if (mem_req && mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= st_wait_release;
                    end
                end
                st_wait_release: begin
                    if (!mem_ack) begin
                        state <= st_finish;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cap_pc     <= in_pc;
            cap_inst   <= in_inst;
            cap_addr   <= in_alu_result;
            cap_data   <= in_store_data;
            cap_wen    <= in_wen;
            cap_store  <= dec_store;
            cap_size   <= dec_size;
            cap_signed <= dec_signed;
        end
        // read data sampled together with the ack
        if (state == st_req && mem_req && mem_ack) begin
            cap_rdata <= mem_rdata;
        end
    end

    store_align store_align_inst (
        .lane       (cap_addr[2:0]),
        .size       (cap_size),
        .store_data (cap_data),
        .lane_data  (mem_wdata),
        .lane_strb  (lane_strb)
    );

    load_extract load_extract_inst (
        .rdata       (cap_rdata),
        .lane        (cap_addr[2:0]),
        .size        (cap_size),
        .signed_load (cap_signed),
        .value       (load_value)
    );

    // bus side, doubleword aligned
    assign mem_we    = cap_store;
    assign mem_addr  = {cap_addr[63:3], 3'b000};
    assign mem_wstrb = cap_store ? lane_strb : '0;

    // memory item presents in finish, non-memory item the cycle after accept
    assign done      = pass_valid || (state == st_finish);
    assign done_pc   = cap_pc;
    assign done_inst = cap_inst;

    always_comb begin
        if (state == st_finish) begin
            // stores report the raw store data
            done_result = cap_store ? cap_data : load_value;
            done_wen    = !cap_store;
            done_kind   = cap_store ? trace_store : trace_load;
            done_addr   = cap_addr;
        end else begin
            done_result = cap_addr;
            done_wen    = cap_wen;
            done_kind   = trace_none;
            done_addr   = '0;
        end
    end

endmodule

// ==== verilog/retire_unit.sv ====
module retire_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  done,
    input  riscv_pkg::xlen_t      done_pc,
    input  riscv_pkg::inst_word_t done_inst,
    input  riscv_pkg::xlen_t      done_result,
    input  logic                  done_wen,
    input  lsu_pkg::trace_kind_t  done_kind,
    input  lsu_pkg::addr_t        done_addr,
    output logic                  retire_valid,
    output riscv_pkg::xlen_t      retire_pc,
    output riscv_pkg::inst_word_t retire_inst,
    output riscv_pkg::xlen_t      retire_wdata,
    output lsu_pkg::trace_kind_t  retire_kind,
    output lsu_pkg::addr_t        retire_addr,
    output logic [31:0]           retire_count,
    output logic                  gpr_we,
    output riscv_pkg::reg_idx_t   gpr_waddr,
    output riscv_pkg::xlen_t      gpr_wdata
);

    // register write request of the current writeback item
    logic retire_wen;

    // writeback stage control
    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            retire_wen   <= 1'b0;
            retire_count <= 32'd0;
        end else begin
            retire_valid <= done;
            retire_wen   <= done && done_wen;
            if (done) begin
                retire_count <= retire_count + 32'd1;
            end
        end
    end

    // writeback payload
    always_ff @(posedge clk) begin
        if (done) begin
            retire_pc    <= done_pc;
            retire_inst  <= done_inst;
            retire_wdata <= done_result;
            retire_kind  <= done_kind;
            retire_addr  <= done_addr;
        end
    end

    // rd sits in the i view, x0 never written
    assign gpr_waddr = retire_inst.i_fields.rd;
    assign gpr_wdata = retire_wdata;
    assign gpr_we    = retire_valid && retire_wen && (gpr_waddr != 5'd0);

endmodule

// ==== verilog/gpr_file.sv ====
module gpr_file (
    input  logic                clk,
    input  logic                rst,
    input  logic                we,
    input  riscv_pkg::reg_idx_t waddr,
    input  riscv_pkg::xlen_t    wdata,
    input  riscv_pkg::reg_idx_t raddr,
    output riscv_pkg::xlen_t    rdata
);
    import riscv_pkg::*;

    // x1..x31, x0 has no storage
    xlen_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // observation port
    assign rdata = (raddr == 5'd0) ? '0 : regs[raddr];

endmodule

// ==== verilog/wb_stage_top.sv ====
module wb_stage_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  riscv_pkg::xlen_t      in_pc,
    input  riscv_pkg::inst_word_t in_inst,
    input  riscv_pkg::xlen_t      in_alu_result,
    input  riscv_pkg::xlen_t      in_store_data,
    input  logic                  in_wen,
    output logic                  mem_req,
    output logic                  mem_we,
    output lsu_pkg::addr_t        mem_addr,
    output riscv_pkg::xlen_t      mem_wdata,
    output lsu_pkg::strb_t        mem_wstrb,
    input  logic                  mem_ack,
    input  riscv_pkg::xlen_t      mem_rdata,
    output logic                  retire_valid,
    output riscv_pkg::xlen_t      retire_pc,
    output riscv_pkg::inst_word_t retire_inst,
    output riscv_pkg::xlen_t      retire_wdata,
    output lsu_pkg::trace_kind_t  retire_kind,
    output lsu_pkg::addr_t        retire_addr,
    output logic [31:0]           retire_count,
    input  riscv_pkg::reg_idx_t   gpr_raddr,
    output riscv_pkg::xlen_t      gpr_rdata
);
    import riscv_pkg::*;
    import lsu_pkg::*;

    // memory stage to writeback
    logic        done;
    xlen_t       done_pc;
    inst_word_t  done_inst;
    xlen_t       done_result;
    logic        done_wen;
    trace_kind_t done_kind;
    addr_t       done_addr;

    // writeback to register file
    logic        gpr_we;
    reg_idx_t    gpr_waddr;
    xlen_t       gpr_wdata;

    lsu_ctrl lsu_ctrl_inst (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_pc         (in_pc),
        .in_inst       (in_inst),
        .in_alu_result (in_alu_result),
        .in_store_data (in_store_data),
        .in_wen        (in_wen),
        .mem_req       (mem_req),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_wstrb     (mem_wstrb),
        .mem_ack       (mem_ack),
        .mem_rdata     (mem_rdata),
        .done          (done),
        .done_pc       (done_pc),
        .done_inst     (done_inst),
        .done_result   (done_result),
        .done_wen      (done_wen),
        .done_kind     (done_kind),
        .done_addr     (done_addr)
    );

    retire_unit retire_unit_inst (
        .clk          (clk),
        .rst          (rst),
        .done         (done),
        .done_pc      (done_pc),
        .done_inst    (done_inst),
        .done_result  (done_result),
        .done_wen     (done_wen),
        .done_kind    (done_kind),
        .done_addr    (done_addr),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_inst  (retire_inst),
        .retire_wdata (retire_wdata),
        .retire_kind  (retire_kind),
        .retire_addr  (retire_addr),
        .retire_count (retire_count),
        .gpr_we       (gpr_we),
        .gpr_waddr    (gpr_waddr),
        .gpr_wdata    (gpr_wdata)
    );

    gpr_file gpr_file_inst (
        .clk   (clk),
        .rst   (rst),
        .we    (gpr_we),
        .waddr (gpr_waddr),
        .wdata (gpr_wdata),
        .raddr (gpr_raddr),
        .rdata (gpr_rdata)
    );

endmodule

// ==== testbench/wb_stage_tb.sv ====
module wb_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import riscv_pkg::*;
    import lsu_pkg::*;

    localparam int num_instr   = 300;
    localparam int cycle_limit = num_instr * 12 + 100;

    // one accepted instruction as queued for the compare
    typedef struct packed {
        xlen_t      pc;
        inst_word_t inst;
        xlen_t      alu;
        xlen_t      sdata;
        logic       wen;
    } item_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    xlen_t       in_pc;
    inst_word_t  in_inst;
    xlen_t       in_alu_result;
    xlen_t       in_store_data;
    logic        in_wen;
    logic        mem_req;
    logic        mem_we;
    addr_t       mem_addr;
    xlen_t       mem_wdata;
    strb_t       mem_wstrb;
    logic        mem_ack = 1'b0;
    xlen_t       mem_rdata = '0;
    logic        retire_valid;
    xlen_t       retire_pc;
    inst_word_t  retire_inst;
    xlen_t       retire_wdata;
    trace_kind_t retire_kind;
    addr_t       retire_addr;
    logic [31:0] retire_count;
    reg_idx_t    gpr_raddr = '0;
    xlen_t       gpr_rdata;

    // memory model contents and the reference copies
    xlen_t       mem_array [64];
    xlen_t       shadow_mem [64];
    xlen_t       shadow_gpr [32];
    item_t       exp_q [$];

    int          checks = 0;
    int          errors = 0;
    int          retired = 0;
    int          cycles = 0;
    int          ack_wait = 0;
    // extra cycles that ack stays high after req falls
    int          rel_wait = 0;
    logic        ack_pending = 1'b0;
    // register to read back one cycle after its retire
    logic        rb_active = 1'b0;
    reg_idx_t    rb_idx = '0;
    logic        mem_busy = 1'b0;
    logic        req_prev = 1'b0;
    logic        ack_prev = 1'b0;

    wb_stage_top wb_stage_top_inst (.*);

    always #5 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_word(input string what, input xlen_t got, input xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_kind(input string what, input trace_kind_t got, input trace_kind_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %s expected %s", $time, what, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_count(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // distinct for every doubleword
    function automatic xlen_t fill_word(input int idx);
        return {32'(idx) * 32'h9e37_79b1, ~(32'(idx) * 32'h85eb_ca6b)};
    endfunction

    // load and store only with a defined funct3
    function automatic trace_kind_t access_kind(input inst_word_t inst);
        if (inst.i_fields.opcode == opcode_load && inst.i_fields.funct3 != 3'b111) begin
            return trace_load;
        end
        if (inst.s_fields.opcode == opcode_store && !inst.s_fields.funct3[2]) begin
            return trace_store;
        end
        return trace_none;
    endfunction

    // expected retire value, trace kind and address
    function automatic void expect_retire(input inst_word_t inst, input xlen_t alu,
                                          input xlen_t sdata, output xlen_t value,
                                          output trace_kind_t kind, output addr_t addr);
        xlen_t dw;
        kind = access_kind(inst);
        // addressed byte moved down to bit 0
        dw = shadow_mem[alu[8:3]] >> (8 * int'(alu[2:0]));
        case (kind)
            trace_load: begin
                addr = alu;
                case (inst.i_fields.funct3)
                    funct3_lb:  value = 64'($signed(dw[7:0]));
                    funct3_lh:  value = 64'($signed(dw[15:0]));
                    funct3_lw:  value = 64'($signed(dw[31:0]));
                    funct3_lbu: value = 64'(dw[7:0]);
                    funct3_lhu: value = 64'(dw[15:0]);
                    funct3_lwu: value = 64'(dw[31:0]);
                    default:    value = dw;
                endcase
            end
            trace_store: begin
                value = sdata;
                addr  = alu;
            end
            default: begin
                value = alu;
                addr  = '0;
            end
        endcase
    endfunction

    // low 1, 2, 4 or 8 bytes of the store data into the shadow doubleword
    task automatic store_to_shadow(input addr_t addr, input logic [2:0] f3, input xlen_t sdata);
        int nbytes;
        nbytes = 1 << f3[1:0];
        for (int b = 0; b < nbytes; b++) begin
            shadow_mem[addr[8:3]][8 * (int'(addr[2:0]) + b) +: 8] = sdata[8 * b +: 8];
        end
    endtask

    task automatic make_instruction(input int n, output item_t it);
        int         sel;
        logic [2:0] f3;
        logic [2:0] off;
        inst_word_t w;
        // sweep of every width and offset before the random mix
        if (n < 112) begin
            sel = (n % 2) + 1;
            f3  = 3'(n / 16);
            off = 3'((n / 2) % 8);
        end else begin
            sel = $urandom_range(2, 0);
            f3  = 3'($urandom_range(6, 0));
            off = 3'($urandom);
        end
        if (sel == 2) begin
            f3[2] = 1'b0;
        end
        // natural alignment
        off = off & ~3'((1 << f3[1:0]) - 1);
        w = $urandom;
        if (sel == 1) begin
            w.i_fields.opcode = opcode_load;
            w.i_fields.funct3 = f3;
        end else if (sel == 2) begin
            w.s_fields.opcode = opcode_store;
            w.s_fields.funct3 = f3;
        end else if (w.i_fields.opcode == opcode_load || w.i_fields.opcode == opcode_store) begin
            // turns load into op-imm and store into op
            w.i_fields.opcode[4] = 1'b1;
        end
        // x0 as destination now and then
        if (n % 8 == 5) begin
            w.i_fields.rd = 5'd0;
        end
        it.pc    = 64'h8000_0000 + 64'(4 * n);
        it.inst  = w;
        it.alu   = (sel == 0) ? {$urandom, $urandom} : {55'd0, 6'($urandom), off};
        it.sdata = {$urandom, $urandom};
        it.wen   = ($urandom_range(3, 0) != 0);
    endtask

    // data memory with ack after 1 to 4 cycles
    always @(posedge clk) begin
        #1;
        if (rst) begin
            mem_ack     = 1'b0;
            ack_pending = 1'b0;
            rel_wait    = 0;
        end else if (mem_ack) begin
            // ack released 0 to 3 cycles after req falls
            if (!mem_req) begin
                if (rel_wait == 0) begin
                    mem_ack = 1'b0;
                end else begin
                    rel_wait = rel_wait - 1;
                end
            end
        end else if (mem_req && !ack_pending) begin
            ack_pending = 1'b1;
            ack_wait    = $urandom_range(4, 1);
        end else if (mem_req) begin
            ack_wait = ack_wait - 1;
            if (ack_wait == 0) begin
                // the access in flight is the newest queued item
                check_word("memory address", mem_addr,
                           exp_q[exp_q.size() - 1].alu & ~64'h7);
                if (mem_we) begin
                    for (int b = 0; b < 8; b++) begin
                        if (mem_wstrb[b]) begin
                            mem_array[mem_addr[8:3]][8 * b +: 8] = mem_wdata[8 * b +: 8];
                        end
                    end
                end else begin
                    mem_rdata = mem_array[mem_addr[8:3]];
                end
                ack_pending = 1'b0;
                rel_wait    = $urandom_range(3, 0);
                mem_ack     = 1'b1;
            end
        end
    end

    // read port follows the last retired rd
    always @(posedge clk) begin
        #1;
        gpr_raddr = rb_idx;
    end

    // compares mid-cycle on the falling edge
    always @(negedge clk) begin
        item_t       it;
        xlen_t       exp_val;
        trace_kind_t exp_kind;
        addr_t       exp_addr;
        if (!rst) begin
            if (rb_active) begin
                check_word("register readback", gpr_rdata, shadow_gpr[rb_idx]);
            end
            rb_active = 1'b0;
            // four-phase rules against the previous sample
            if (req_prev && !mem_req && !ack_prev) begin
                errors++;
                $display("handshake broken at %0t: req dropped before ack was high", $time);
            end
            if (!req_prev && mem_req && ack_prev) begin
                errors++;
                $display("handshake broken at %0t: req raised while ack was high", $time);
            end
            if (retire_valid && exp_q.size() == 0) begin
                errors++;
                $display("retire at %0t with no instruction outstanding", $time);
            end else if (retire_valid) begin
                it = exp_q.pop_front();
                expect_retire(it.inst, it.alu, it.sdata, exp_val, exp_kind, exp_addr);
                retired++;
                check_word("retire pc", retire_pc, it.pc);
                check_word("retire inst", {32'd0, retire_inst}, {32'd0, it.inst});
                check_word("retire value", retire_wdata, exp_val);
                check_kind("retire kind", retire_kind, exp_kind);
                check_word("retire address", retire_addr, exp_addr);
                check_count("retire count", retire_count, 32'(retired));
                case (exp_kind)
                    trace_load: begin
                        if (it.inst.i_fields.rd != 5'd0) begin
                            shadow_gpr[it.inst.i_fields.rd] = exp_val;
                        end
                        mem_busy = 1'b0;
                    end
                    trace_store: begin
                        store_to_shadow(it.alu, it.inst.s_fields.funct3, it.sdata);
                        check_word("memory doubleword", mem_array[it.alu[8:3]],
                                   shadow_mem[it.alu[8:3]]);
                        mem_busy = 1'b0;
                    end
                    default: begin
                        if (it.wen && it.inst.i_fields.rd != 5'd0) begin
                            shadow_gpr[it.inst.i_fields.rd] = it.alu;
                        end
                    end
                endcase
                rb_active = 1'b1;
                rb_idx    = it.inst.i_fields.rd;
            end
            if (mem_busy && in_ready) begin
                errors++;
                $display("in_ready high at %0t while a memory access is outstanding", $time);
            end
            if (in_valid && in_ready && access_kind(in_inst) != trace_none) begin
                mem_busy = 1'b1;
            end
        end
        req_prev = mem_req;
        ack_prev = mem_ack;
    end

    initial begin
        item_t it;
        void'($urandom(32'h0555b0e6));
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_pc         = '0;
        in_inst       = '0;
        in_alu_result = '0;
        in_store_data = '0;
        in_wen        = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem_array[i]  = fill_word(i);
            shadow_mem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            shadow_gpr[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        if (!in_ready || mem_req || retire_valid) begin
            errors++;
            $display("wrong state after reset: in_ready %b mem_req %b retire_valid %b",
                     in_ready, mem_req, retire_valid);
        end
        check_count("retire count after reset", retire_count, 32'd0);
        @(posedge clk);
        #1;
        for (int n = 0; n < num_instr; n++) begin
            make_instruction(n, it);
            // occasional bubble on the input side
            if ($urandom_range(7, 0) == 0) begin
                in_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            in_valid      = 1'b1;
            in_pc         = it.pc;
            in_inst       = it.inst;
            in_alu_result = it.alu;
            in_store_data = it.sdata;
            in_wen        = it.wen;
            @(negedge clk);
            while (!in_ready) begin
                @(negedge clk);
            end
            exp_q.push_back(it);
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        while (retired < num_instr) begin
            @(posedge clk);
        end
        // last readback
        repeat (2) @(posedge clk);
        check_count("final retire count", retire_count, 32'(num_instr));
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d accepted instructions never retired", exp_q.size());
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/riscv_pkg.sv
verilog/lsu_pkg.sv
verilog/store_align.sv
verilog/load_extract.sv
verilog/lsu_ctrl.sv
verilog/retire_unit.sv
verilog/gpr_file.sv
verilog/wb_stage_top.sv
testbench/wb_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
verilator --binary --timing --top-module wb_stage_tb -f tb.f -o wb_stage_sim \
    && ./obj_dir/wb_stage_sim | tee /dev/stderr | grep -q "TEST PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
